//--- src.f
+incdir+.
dma_pkg.sv
wr_realign.sv
recv_desc_builder.sv
axis_to_mem_dma.sv
axis_to_mem_dma_asserts.sv
tb_axis_to_mem_dma.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_axis_to_mem_dma
FILELIST  := src.f
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
SIM_ARGS  := +verilator+error+limit+100
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully
SOURCES   := $(filter %.sv,$(shell cat $(FILELIST)))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES) dma_defines.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_axis_to_mem_dma.sv
`include "dma_defines.svh"

module tb_axis_to_mem_dma
  import dma_pkg::*;
();

  localparam int NUM_PKTS       = 200;
  localparam int MAX_LEN        = 40;
  localparam int TIMEOUT_CYCLES = 60 * NUM_PKTS + 20;

  logic  clk;
  logic  rst;
  data_t s_axis_tdata;
  strb_t s_axis_tkeep;
  logic  s_axis_tvalid;
  logic  s_axis_tready;
  logic  s_axis_tlast;
  dest_t s_axis_tdest;
  user_t s_axis_tuser;
  addr_t wr_base_addr;
  logic  mem_wr_en;
  strb_t mem_wr_strb;
  addr_t mem_wr_addr;
  data_t mem_wr_data;
  logic  mem_wr_last;
  logic  mem_wr_ready;
  logic  recv_desc_valid;
  logic  recv_desc_ready;
  addr_t recv_desc_addr;
  len_t  recv_desc_len;
  dest_t recv_desc_tdest;
  user_t recv_desc_tuser;

  // Expected packets are filled in before each packet is driven
  addr_t      exp_base [NUM_PKTS];
  int         exp_len  [NUM_PKTS];
  dest_t      exp_dest [NUM_PKTS];
  user_t      exp_user [NUM_PKTS];
  logic [7:0] exp_data [NUM_PKTS][MAX_LEN];

  // Byte memory model where owner records which packet wrote each byte
  logic [7:0] mem      [0:65535];
  int         owner    [0:65535];
  int         wr_count [NUM_PKTS];
  int         wr_pkt      = 0;
  int         desc_idx    = 0;
  int         cycle_count = 0;

  axis_to_mem_dma axis_to_mem_dma_i (.*);

  bind axis_to_mem_dma axis_to_mem_dma_asserts asserts_i (
    .clk(clk), .rst(rst), .s_axis_tready(s_axis_tready), .s_axis_tlast(s_axis_tlast),
    .mem_wr_en(mem_wr_en), .mem_wr_ready(mem_wr_ready), .mem_wr_addr(mem_wr_addr),
    .mem_wr_data(mem_wr_data), .mem_wr_strb(mem_wr_strb), .mem_wr_last(mem_wr_last),
    .word_first(word_first), .recv_desc_valid(recv_desc_valid),
    .recv_desc_ready(recv_desc_ready), .recv_desc_addr(recv_desc_addr),
    .recv_desc_len(recv_desc_len), .recv_desc_tdest(recv_desc_tdest),
    .recv_desc_tuser(recv_desc_tuser)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (exp === act)
    else begin
      $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic expect_idle(input string name);
    check_value({name, " mem_wr_en"}, 64'd0, 64'(mem_wr_en));
    check_value({name, " recv_desc_valid"}, 64'd0, 64'(recv_desc_valid));
  endtask

  // Descriptor fields are compared first and then every byte in memory
  task automatic verify_packet(input int p);
    addr_t a;
    check_value($sformatf("desc_addr pkt %0d", p), 64'(exp_base[p]), 64'(recv_desc_addr));
    check_value($sformatf("desc_len pkt %0d", p), 64'(exp_len[p]), 64'(recv_desc_len));
    check_value($sformatf("desc_tdest pkt %0d", p), 64'(exp_dest[p]), 64'(recv_desc_tdest));
    check_value($sformatf("desc_tuser pkt %0d", p), 64'(exp_user[p]), 64'(recv_desc_tuser));
    for (int k = 0; k < exp_len[p]; k++) begin
      a = exp_base[p] + addr_t'(k);
      check_value($sformatf("owner pkt %0d byte %0d", p, k), 64'(p), 64'(owner[a]));
      check_value($sformatf("data pkt %0d byte %0d", p, k), 64'(exp_data[p][k]), 64'(mem[a]));
    end
    // Equal count means nothing was written outside the packet's bytes
    check_value($sformatf("write_count pkt %0d", p), 64'(exp_len[p]), 64'(wr_count[p]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic send_packet(input int p);
    int    len;
    int    words;
    int    idx;
    logic  accepted;
    data_t d;
    strb_t k;
    len = $urandom_range(1, MAX_LEN);
    exp_len[p] = len;
    // Each packet gets its own 64 byte slot among eight, so a later packet
    // never overwrites bytes that are still waiting for their check
    exp_base[p] = addr_t'(($urandom & 32'h0000_fe00) | ((p % 8) << 6) | $urandom_range(0, 23));
    exp_dest[p] = dest_t'($urandom);
    exp_user[p] = user_t'($urandom);
    for (int i = 0; i < len; i++) begin
      exp_data[p][i] = 8'($urandom);
    end
    words = (len + `DMA_STRB_WIDTH - 1) / `DMA_STRB_WIDTH;
    wr_base_addr = exp_base[p];
    s_axis_tdest = exp_dest[p];
    s_axis_tuser = exp_user[p];
    for (int w = 0; w < words; w++) begin
      // Only the first word carries the base address and the tags
      if (w > 0) begin
        wr_base_addr = addr_t'($urandom);
        s_axis_tdest = dest_t'($urandom);
        s_axis_tuser = user_t'($urandom);
      end
      // Keep is low justified and bytes past the end carry junk
      for (int b = 0; b < `DMA_STRB_WIDTH; b++) begin
        idx = w * `DMA_STRB_WIDTH + b;
        k[b] = (idx < len);
        d[b*8 +: 8] = (idx < len) ? exp_data[p][idx] : 8'($urandom);
      end
      s_axis_tdata  = d;
      s_axis_tkeep  = k;
      s_axis_tlast  = (w == words - 1);
      s_axis_tvalid = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = s_axis_tready;
        @(posedge clk);
        #1;
      end
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      if ($urandom_range(0, 3) == 0) begin
        repeat ($urandom_range(1, 2)) begin
          @(posedge clk);
          #1;
        end
      end
    end
  endtask

  // Random back-pressure on both output ports
  always @(posedge clk) begin
    #1;
    mem_wr_ready    = ($urandom_range(0, 3) != 0);
    recv_desc_ready = ($urandom_range(0, 2) == 0);
  end

  //////////////////////////////////////////////////////////////////////
  // Monitors and run control
  //////////////////////////////////////////////////////////////////////

  // Writes are stored before descriptors are checked in the same cycle
  always @(negedge clk) begin
    addr_t a;
    if (!rst && mem_wr_en && mem_wr_ready) begin
      if (wr_pkt >= NUM_PKTS) begin
        $display("Memory write seen after the last packet had ended");
        fail_run();
      end else begin
        for (int b = 0; b < `DMA_STRB_WIDTH; b++) begin
          if (mem_wr_strb[b]) begin
            a = mem_wr_addr + addr_t'(b);
            mem[a] = mem_wr_data[b*8 +: 8];
            owner[a] = wr_pkt;
            wr_count[wr_pkt]++;
          end
        end
        if (mem_wr_last) begin
          wr_pkt++;
        end
      end
    end
    if (!rst && recv_desc_valid && recv_desc_ready) begin
      if (desc_idx >= NUM_PKTS) begin
        $display("Descriptor seen after all packets were reported");
        fail_run();
      end else begin
        verify_packet(desc_idx);
        desc_idx++;
      end
    end
  end

  always @(negedge clk) begin
    if (rst && cycle_count > 0) begin
      expect_idle("reset");
    end
    if (axis_to_mem_dma_i.asserts_i.violations != 0) begin
      $display("A protocol assertion on the DUT failed");
      fail_run();
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d descriptors seen",
               cycle_count, desc_idx, NUM_PKTS);
      fail_run();
    end
  end

  initial begin
    void'($urandom(32'hea13_f94c));
    clk             = 1'b0;
    rst             = 1'b1;
    s_axis_tdata    = '0;
    s_axis_tkeep    = '0;
    s_axis_tvalid   = 1'b0;
    s_axis_tlast    = 1'b0;
    s_axis_tdest    = '0;
    s_axis_tuser    = '0;
    wr_base_addr    = '0;
    mem_wr_ready    = 1'b0;
    recv_desc_ready = 1'b0;
    foreach (owner[i]) begin
      owner[i] = -1;
    end
    foreach (wr_count[i]) begin
      wr_count[i] = 0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    @(negedge clk);
    expect_idle("after_reset");
    @(posedge clk);
    #1;
    for (int p = 0; p < NUM_PKTS; p++) begin
      send_packet(p);
    end
    wait (desc_idx == NUM_PKTS);
    repeat (4) @(posedge clk);
    if (wr_pkt == NUM_PKTS && axis_to_mem_dma_i.asserts_i.violations == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      if (wr_pkt != NUM_PKTS) begin
        $display("mismatch packet_count: expected %0d, actual %0d", NUM_PKTS, wr_pkt);
      end else begin
        $display("A protocol assertion on the DUT failed");
      end
      fail_run();
    end
  end

endmodule

//--- axis_to_mem_dma_asserts.sv
`include "dma_defines.svh"

module axis_to_mem_dma_asserts
  import dma_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input logic  s_axis_tready,
  input logic  s_axis_tlast,
  input logic  mem_wr_en,
  input logic  mem_wr_ready,
  input addr_t mem_wr_addr,
  input data_t mem_wr_data,
  input strb_t mem_wr_strb,
  input logic  mem_wr_last,
  input logic  word_first,
  input logic  recv_desc_valid,
  input logic  recv_desc_ready,
  input addr_t recv_desc_addr,
  input len_t  recv_desc_len,
  input dest_t recv_desc_tdest,
  input user_t recv_desc_tuser
);

  // Failed property count, watched from the testbench top
  int violations = 0;

  logic  wr_hs;
  logic  in_pkt;
  addr_t prev_addr;

  assign wr_hs = mem_wr_en && mem_wr_ready;

  // Open between the first write of a packet and its last write
  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt <= 1'b0;
    end else if (wr_hs) begin
      in_pkt <= !mem_wr_last;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      prev_addr <= mem_wr_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake stability
  //////////////////////////////////////////////////////////////////////

  // A stalled memory write keeps its whole payload
  assert property (@(posedge clk) disable iff (rst)
    (mem_wr_en && !mem_wr_ready) |=> (mem_wr_en &&
      $stable({mem_wr_addr, mem_wr_data, mem_wr_strb, mem_wr_last})))
  else begin
    violations = violations + 1;
    $error("memory write changed while mem_wr_ready was low");
  end

  // A waiting descriptor holds until the consumer takes it
  assert property (@(posedge clk) disable iff (rst)
    (recv_desc_valid && !recv_desc_ready) |=> (recv_desc_valid &&
      $stable({recv_desc_addr, recv_desc_len, recv_desc_tdest, recv_desc_tuser})))
  else begin
    violations = violations + 1;
    $error("receive descriptor changed before it was accepted");
  end

  // The last word of the next packet is held off while a descriptor waits
  assert property (@(posedge clk) disable iff (rst)
    (recv_desc_valid && !recv_desc_ready && s_axis_tlast) |-> !s_axis_tready)
  else begin
    violations = violations + 1;
    $error("last stream word accepted while a descriptor was stalled");
  end

  //////////////////////////////////////////////////////////////////////
  // Write framing
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (rst)
    mem_wr_en |-> (mem_wr_addr[`DMA_MASK_BITS-1:0] == '0))
  else begin
    violations = violations + 1;
    $error("memory write address is not word aligned");
  end

  // A new packet only starts after the previous one wrote its last word
  assert property (@(posedge clk) disable iff (rst)
    (wr_hs && word_first) |-> !in_pkt)
  else begin
    violations = violations + 1;
    $error("packet started before the previous last write");
  end

  // Inside a packet the address steps by exactly one word
  assert property (@(posedge clk) disable iff (rst)
    (wr_hs && !word_first) |->
      (in_pkt && (mem_wr_addr == prev_addr + addr_t'(`DMA_STRB_WIDTH))))
  else begin
    violations = violations + 1;
    $error("memory write outside a packet or with a wrong address step");
  end

endmodule

//--- axis_to_mem_dma.sv
module axis_to_mem_dma
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  // Stream in
  input  data_t s_axis_tdata,
  input  strb_t s_axis_tkeep,
  input  logic  s_axis_tvalid,
  output logic  s_axis_tready,
  input  logic  s_axis_tlast,
  input  dest_t s_axis_tdest,
  input  user_t s_axis_tuser,
  input  addr_t wr_base_addr,

  // Memory write port
  output logic  mem_wr_en,
  output strb_t mem_wr_strb,
  output addr_t mem_wr_addr,
  output data_t mem_wr_data,
  output logic  mem_wr_last,
  input  logic  mem_wr_ready,

  // Receive descriptor
  output logic  recv_desc_valid,
  input  logic  recv_desc_ready,
  output addr_t recv_desc_addr,
  output len_t  recv_desc_len,
  output dest_t recv_desc_tdest,
  output user_t recv_desc_tuser
);

  // Packet boundary and first-word markers from the datapath
  logic pkt_start;
  logic word_first;

  // Descriptor waiting, holds off the last word of the next packet
  logic desc_stall;

  wr_realign wr_realign_i (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .wr_base_addr  (wr_base_addr),
    .desc_stall    (desc_stall),
    .mem_wr_ready  (mem_wr_ready),
    .mem_wr_en     (mem_wr_en),
    .mem_wr_addr   (mem_wr_addr),
    .mem_wr_data   (mem_wr_data),
    .mem_wr_strb   (mem_wr_strb),
    .mem_wr_last   (mem_wr_last),
    .pkt_start     (pkt_start),
    .word_first    (word_first)
  );

  // Watches the memory port handshakes and builds one descriptor per packet
  recv_desc_builder recv_desc_builder_i (
    .clk             (clk),
    .rst             (rst),
    .pkt_start       (pkt_start),
    .word_first      (word_first),
    .wr_base_addr    (wr_base_addr),
    .s_axis_tdest    (s_axis_tdest),
    .s_axis_tuser    (s_axis_tuser),
    .mem_wr_en       (mem_wr_en),
    .mem_wr_last     (mem_wr_last),
    .mem_wr_ready    (mem_wr_ready),
    .mem_wr_strb     (mem_wr_strb),
    .recv_desc_ready (recv_desc_ready),
    .desc_stall      (desc_stall),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_addr  (recv_desc_addr),
    .recv_desc_len   (recv_desc_len),
    .recv_desc_tdest (recv_desc_tdest),
    .recv_desc_tuser (recv_desc_tuser)
  );

endmodule

//--- recv_desc_builder.sv
`include "dma_defines.svh"

module recv_desc_builder
  import dma_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  pkt_start,
  input  logic  word_first,
  input  addr_t wr_base_addr,
  input  dest_t s_axis_tdest,
  input  user_t s_axis_tuser,
  input  logic  mem_wr_en,
  input  logic  mem_wr_last,
  input  logic  mem_wr_ready,
  input  strb_t mem_wr_strb,
  input  logic  recv_desc_ready,
  output logic  desc_stall,
  output logic  recv_desc_valid,
  output addr_t recv_desc_addr,
  output len_t  recv_desc_len,
  output dest_t recv_desc_tdest,
  output user_t recv_desc_tuser
);

  // Metadata of the packet currently being written
  addr_t cur_addr;
  dest_t cur_dest;
  user_t cur_user;

  len_t  wr_ones;
  len_t  len_acc;
  len_t  len_sum;
  logic  wr_hs;
  logic  last_hs;

  // A finished packet whose descriptor could not be loaded yet
  logic  pend_valid;
  addr_t pend_addr;
  len_t  pend_len;
  dest_t pend_dest;
  user_t pend_user;

  logic  load_now;
  logic  load_pend;

  assign wr_hs   = mem_wr_en && mem_wr_ready;
  assign last_hs = wr_hs && mem_wr_last;

  always_ff @(posedge clk) begin
    if (pkt_start) begin
      cur_addr <= wr_base_addr;
      cur_dest <= s_axis_tdest;
      cur_user <= s_axis_tuser;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte count
  //////////////////////////////////////////////////////////////////////

  // Strobes may have holes on the first and last word, so count bits
  always_comb begin
    wr_ones = '0;
    for (int i = 0; i < `DMA_STRB_WIDTH; i++) begin
      wr_ones = wr_ones + len_t'(mem_wr_strb[i]);
    end
  end

  assign len_sum = word_first ? wr_ones : len_acc + wr_ones;

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      len_acc <= len_sum;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Descriptor output
  //////////////////////////////////////////////////////////////////////

  assign desc_stall = recv_desc_valid && !recv_desc_ready;
  assign load_now   = last_hs && !desc_stall;
  assign load_pend  = pend_valid && recv_desc_ready;

  // Late write, the previous descriptor is still waiting
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
    end else if (last_hs && desc_stall) begin
      pend_valid <= 1'b1;
    end else if (load_pend) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (last_hs && desc_stall) begin
      pend_addr <= cur_addr;
      pend_len  <= len_sum;
      pend_dest <= cur_dest;
      pend_user <= cur_user;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      recv_desc_valid <= 1'b0;
    end else if (load_pend || load_now) begin
      recv_desc_valid <= 1'b1;
    end else if (recv_desc_ready) begin
      recv_desc_valid <= 1'b0;
    end
  end

  // The pending packet is older, so it goes out first
  always_ff @(posedge clk) begin
    if (load_pend) begin
      recv_desc_addr  <= pend_addr;
      recv_desc_len   <= pend_len;
      recv_desc_tdest <= pend_dest;
      recv_desc_tuser <= pend_user;
    end else if (load_now) begin
      recv_desc_addr  <= cur_addr;
      recv_desc_len   <= len_sum;
      recv_desc_tdest <= cur_dest;
      recv_desc_tuser <= cur_user;
    end
  end

endmodule

//--- wr_realign.sv
`include "dma_defines.svh"

module wr_realign
  import dma_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  data_t   s_axis_tdata,
  input  strb_t   s_axis_tkeep,
  input  logic    s_axis_tvalid,
  input  logic    s_axis_tlast,
  output logic    s_axis_tready,
  input  addr_t   wr_base_addr,
  input  logic    desc_stall,
  input  logic    mem_wr_ready,
  output logic    mem_wr_en,
  output addr_t   mem_wr_addr,
  output data_t   mem_wr_data,
  output strb_t   mem_wr_strb,
  output logic    mem_wr_last,
  output logic    pkt_start,
  output logic    word_first
);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  wr_state_t state_r;
  wr_state_t state_n;

  // Stage 1 holds the newest accepted word, stage 2 the one before it
  data_t   data_1;
  data_t   data_2;
  strb_t   strb_1;
  strb_t   strb_2;
  logic    last_1;

  // Bytes of the stage 1 word that spill past the current memory word
  logic    strb_left;
  logic    extra_cycle;
  logic    extra_r;

  logic    data_en;
  logic    first_r;
  logic    accept;
  logic    wr_hs;
  logic    last_pkt;

  offset_t offset_r;
  offset_t new_offset;
  addr_t   base_aligned;
  addr_t   next_addr;

  logic [2*`DMA_DATA_WIDTH-1:0] data_cat;
  logic [2*`DMA_STRB_WIDTH-1:0] strb_cat;

  assign accept = s_axis_tvalid && s_axis_tready;
  assign wr_hs  = data_en && mem_wr_ready;

  // An extra word is owed when the last input word still has bytes
  // beyond the shift point
  assign extra_cycle = last_1 && strb_left;

  // The final write is either the last input word itself or the extra
  // word that drains stage 2
  assign last_pkt = data_en && ((last_1 && !extra_cycle) || extra_r);

  // First word of a packet, either from idle or overlapping the final
  // write of the previous packet
  assign pkt_start = ((state_r == wr_idle) || (last_pkt && mem_wr_ready)) && accept;

  always_comb begin
    state_n = state_r;
    if ((state_r == wr_idle) && accept) begin
      state_n = wr_proc;
    end else if ((state_r == wr_proc) && last_pkt && mem_wr_ready && !accept) begin
      state_n = wr_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_r <= wr_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // Input is held off while the extra word goes out, and the last word
  // of a packet waits while the previous descriptor is not taken
  assign s_axis_tready = mem_wr_ready && !extra_cycle && !(s_axis_tlast && desc_stall);

  //////////////////////////////////////////////////////////////////////
  // Alignment and pipeline
  //////////////////////////////////////////////////////////////////////

  // Shift that moves packet byte 0 to the low address bits of the base
  assign new_offset = offset_t'(`DMA_STRB_WIDTH) -
                      offset_t'(wr_base_addr[`DMA_MASK_BITS-1:0]);

  always_ff @(posedge clk) begin
    if (pkt_start) begin
      offset_r     <= new_offset;
      base_aligned <= {wr_base_addr[`DMA_ADDR_WIDTH-1:`DMA_MASK_BITS],
                       {`DMA_MASK_BITS{1'b0}}};
    end
  end

  // Spill check is done at accept time so the extra decision is a
  // register when the word reaches the memory port
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_left <= 1'b0;
    end else if (extra_cycle && wr_hs) begin
      strb_left <= 1'b0;
    end else if (pkt_start) begin
      strb_left <= |(s_axis_tkeep >> new_offset);
    end else if (accept) begin
      strb_left <= |(s_axis_tkeep >> offset_r);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_1 <= s_axis_tdata;
    end
    if (wr_hs) begin
      data_2 <= data_1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      strb_1  <= '0;
      last_1  <= 1'b0;
      strb_2  <= '0;
      extra_r <= 1'b0;
    end else begin
      // The extra word empties stage 1 so only leftover bytes remain
      if (extra_cycle && wr_hs) begin
        strb_1 <= '0;
        last_1 <= 1'b0;
      end else if (accept) begin
        strb_1 <= s_axis_tkeep;
        last_1 <= s_axis_tlast;
      end
      // Stage 2 is cleared at packet end so the next first word starts clean
      if (last_pkt && mem_wr_ready) begin
        strb_2 <= '0;
      end else if (wr_hs) begin
        strb_2 <= strb_1;
      end
      if (wr_hs) begin
        extra_r <= extra_cycle;
      end
    end
  end

  // A write is pending after an accept, stays up under back-pressure,
  // and is repeated once for the extra word
  always_ff @(posedge clk) begin
    if (rst) begin
      data_en <= 1'b0;
      first_r <= 1'b0;
    end else begin
      data_en <= accept || (data_en && (!mem_wr_ready || extra_cycle));
      first_r <= pkt_start || (first_r && !mem_wr_ready);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory write port
  //////////////////////////////////////////////////////////////////////

  // Address steps one word per accepted write
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      next_addr <= mem_wr_addr + addr_t'(`DMA_STRB_WIDTH);
    end
  end

  assign data_cat = {data_1, data_2} >> {offset_r, 3'd0};
  assign strb_cat = {strb_1, strb_2} >> offset_r;

  assign mem_wr_en   = data_en;
  assign mem_wr_addr = first_r ? base_aligned : next_addr;
  assign mem_wr_data = data_cat[`DMA_DATA_WIDTH-1:0];
  assign mem_wr_strb = strb_cat[`DMA_STRB_WIDTH-1:0];
  assign mem_wr_last = last_pkt;
  assign word_first  = first_r;

endmodule

//--- dma_pkg.sv
`include "dma_defines.svh"

package dma_pkg;

  // One data word of the stream and of the memory
  typedef logic [`DMA_DATA_WIDTH-1:0] data_t;

  // Byte enables on the memory side, keep mask on the stream side
  typedef logic [`DMA_STRB_WIDTH-1:0] strb_t;

  // Byte address and byte count
  typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DMA_LEN_WIDTH-1:0]  len_t;

  // Stream tags carried into the descriptor
  typedef logic [`DMA_DEST_WIDTH-1:0] dest_t;
  typedef logic [`DMA_USER_WIDTH-1:0] user_t;

  // Shift in bytes, the extra top bit lets it reach a full word
  typedef logic [`DMA_MASK_BITS:0] offset_t;

  // Write side state machine
  typedef enum logic {
    wr_idle,
    wr_proc
  } wr_state_t;

endpackage

//--- dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Width of one stream word and one memory word in bits
`define DMA_DATA_WIDTH 64

// Bytes per word, one strobe or keep bit per byte
`define DMA_STRB_WIDTH 8

// Byte address width of the memory write port
`define DMA_ADDR_WIDTH 16

// Packet length in bytes as reported by the receive descriptor
`define DMA_LEN_WIDTH 16

// Stream routing tag and user tag widths
`define DMA_DEST_WIDTH 8
`define DMA_USER_WIDTH 2

// Address bits that select a byte inside one word
`define DMA_MASK_BITS 3

`endif
